// ==== design/decodeStage.sv ====
// Decode stage with control generation, operand forwarding and the decode-to-execute register
`default_nettype none
`timescale 1ns/1ps

module decodeStage #(
    parameter int AddrWidth = 16
) (
    input  logic                    Clock,
    input  logic                    nReset,
    input  pipePkg::fetchDecode_t   FetchIn,
    input  logic                    Stall,
    input  logic                    Redirect,
    input  pipePkg::forwardSel_e    ForwardA,
    input  pipePkg::forwardSel_e    ForwardB,
    input  logic [31:0]             ExecResult,
    input  logic [31:0]             MemResult,
    input  pipePkg::writePort_t     WritePort,
    input  logic [4:0]              RegAddr,
    output logic [4:0]              RsAddr,
    output logic [4:0]              RtAddr,
    output pipePkg::decodeExecute_t DecodeOut,
    output logic [31:0]             RegData
);

    isaPkg::instr_u Instr;
    pipePkg::ctrl_t Ctrl;
    logic [4:0]     DestAddr;
    logic [31:0]    Imm;
    logic [31:0]    RsFile;
    logic [31:0]    RtFile;
    logic [31:0]    RsFwd;
    logic [31:0]    RtFwd;

    // Pipeline structs carry a 16-bit Pc
    if (AddrWidth > 16)
    begin : gPcWidthCheck
        $error("AddrWidth exceeds the 16-bit Pc field");
    end

    assign Instr  = FetchIn.Instr;
    assign RsAddr = Instr.R.Rs;
    assign RtAddr = Instr.R.Rt;

    regFile u_regFile (
        .Clock    (Clock),
        .nReset   (nReset),
        .RsAddr   (RsAddr),
        .RtAddr   (RtAddr),
        .RegAddr  (RegAddr),
        .WritePort(WritePort),
        .RsData   (RsFile),
        .RtData   (RtFile),
        .RegData  (RegData)
    );

    // -------------------------------------------------------------------
    // Control decode
    // -------------------------------------------------------------------
    always_comb
    begin
        Ctrl     = '0;
        DestAddr = Instr.I.Rt;
        Imm      = {{16{Instr.I.Imm16[15]}}, Instr.I.Imm16};
        case (Instr.R.Opcode)
            isaPkg::OpSpecial:
            begin
                DestAddr      = Instr.R.Rd;
                Ctrl.RegWrite = 1'b1;
                case (Instr.R.Funct)
                    isaPkg::FnAddu: Ctrl.AluOp = isaPkg::AluAdd;
                    isaPkg::FnSubu: Ctrl.AluOp = isaPkg::AluSub;
                    isaPkg::FnAnd:  Ctrl.AluOp = isaPkg::AluAnd;
                    isaPkg::FnOr:   Ctrl.AluOp = isaPkg::AluOr;
                    isaPkg::FnXor:  Ctrl.AluOp = isaPkg::AluXor;
                    isaPkg::FnSlt:  Ctrl.AluOp = isaPkg::AluSlt;
                    isaPkg::FnSll:  Ctrl.AluOp = isaPkg::AluSll;
                    default:        Ctrl.RegWrite = 1'b0;
                endcase
            end
            isaPkg::OpAddiu:
            begin
                Ctrl.RegWrite  = 1'b1;
                Ctrl.AluSrcImm = 1'b1;
            end
            isaPkg::OpOri:
            begin
                Ctrl.RegWrite  = 1'b1;
                Ctrl.AluSrcImm = 1'b1;
                Ctrl.AluOp     = isaPkg::AluOr;
                Imm            = {16'b0, Instr.I.Imm16};
            end
            isaPkg::OpLw:
            begin
                Ctrl.RegWrite  = 1'b1;
                Ctrl.MemRead   = 1'b1;
                Ctrl.MemToReg  = 1'b1;
                Ctrl.AluSrcImm = 1'b1;
            end
            isaPkg::OpSw:
            begin
                Ctrl.MemWrite  = 1'b1;
                Ctrl.AluSrcImm = 1'b1;
            end
            isaPkg::OpBeq: Ctrl.Branch = 1'b1;
            isaPkg::OpBne:
            begin
                Ctrl.Branch   = 1'b1;
                Ctrl.BranchNe = 1'b1;
            end
            isaPkg::OpJ:
            begin
                Ctrl.Jump = 1'b1;
                Imm       = {6'b0, Instr.Raw[25:0]};
            end
            default: ;
        endcase
    end

    function automatic logic [31:0] forwardMux(input pipePkg::forwardSel_e Sel,
                                               input logic [31:0] FileData);
        case (Sel)
            pipePkg::FwdExec: return ExecResult;
            pipePkg::FwdMem:  return MemResult;
            pipePkg::FwdWb:   return WritePort.Data;
            default:          return FileData;
        endcase
    endfunction

    always_comb
    begin
        RsFwd = forwardMux(ForwardA, RsFile);
        RtFwd = forwardMux(ForwardB, RtFile);
    end

    // Bubble on a load-use hold or a squash
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
            DecodeOut <= '0;
        else if (Stall || Redirect)
            DecodeOut.Valid <= 1'b0;
        else
        begin
            DecodeOut.Valid    <= FetchIn.Valid;
            DecodeOut.Ctrl     <= Ctrl;
            DecodeOut.Pc       <= FetchIn.Pc;
            DecodeOut.RsAddr   <= RsAddr;
            DecodeOut.RtAddr   <= RtAddr;
            DecodeOut.DestAddr <= DestAddr;
            DecodeOut.RsData   <= RsFwd;
            DecodeOut.RtData   <= RtFwd;
            DecodeOut.Imm      <= Imm;
            DecodeOut.Shamt    <= Instr.R.Shamt;
        end
    end

endmodule

`default_nettype wire

// ==== design/executeStage.sv ====
// Execute stage with the ALU, branch resolution and the execute-to-memory register
`default_nettype none
`timescale 1ns/1ps

module executeStage #(
    parameter int AddrWidth = 16
) (
    input  logic                    Clock,
    input  logic                    nReset,
    input  pipePkg::decodeExecute_t DecodeIn,
    output logic [31:0]             ExecResult,
    output logic                    Redirect,
    output logic [AddrWidth-1:0]    TargetPc,
    output pipePkg::executeMemory_t ExecOut
);

    logic [31:0]          OpB;
    logic [31:0]          AluResult;
    logic                 Taken;
    logic [AddrWidth-1:0] PcPlus4;
    logic [AddrWidth-1:0] BranchTarget;
    logic [AddrWidth-1:0] JumpTarget;

    assign OpB = DecodeIn.Ctrl.AluSrcImm ? DecodeIn.Imm : DecodeIn.RtData;

    always_comb
    begin
        case (DecodeIn.Ctrl.AluOp)
            isaPkg::AluAdd: AluResult = DecodeIn.RsData + OpB;
            isaPkg::AluSub: AluResult = DecodeIn.RsData - OpB;
            isaPkg::AluAnd: AluResult = DecodeIn.RsData & OpB;
            isaPkg::AluOr:  AluResult = DecodeIn.RsData | OpB;
            isaPkg::AluXor: AluResult = DecodeIn.RsData ^ OpB;
            isaPkg::AluSlt: AluResult = {31'b0, $signed(DecodeIn.RsData) < $signed(OpB)};
            isaPkg::AluSll: AluResult = OpB << DecodeIn.Shamt;
            default:        AluResult = '0;
        endcase
    end

    assign ExecResult = AluResult;

    // -------------------------------------------------------------------
    // Branch and jump resolution
    // -------------------------------------------------------------------
    assign Taken = DecodeIn.Ctrl.Jump
                || (DecodeIn.Ctrl.Branch
                    && ((DecodeIn.RsData == DecodeIn.RtData) != DecodeIn.Ctrl.BranchNe));
    assign Redirect = DecodeIn.Valid && Taken;

    assign PcPlus4      = AddrWidth'(DecodeIn.Pc) + AddrWidth'(4);
    assign BranchTarget = PcPlus4 + AddrWidth'(DecodeIn.Imm << 2);
    // Pc is narrower than the 28-bit jump range
    assign JumpTarget   = AddrWidth'({DecodeIn.Imm[25:0], 2'b00});
    assign TargetPc     = DecodeIn.Ctrl.Jump ? JumpTarget : BranchTarget;

    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
            ExecOut <= '0;
        else
        begin
            ExecOut.Valid     <= DecodeIn.Valid;
            ExecOut.Ctrl      <= DecodeIn.Ctrl;
            ExecOut.DestAddr  <= DecodeIn.DestAddr;
            ExecOut.AluResult <= AluResult;
            ExecOut.StoreData <= DecodeIn.RtData;
        end
    end

    // The slot behind a redirect is squashed by decode
    assert property (@(posedge Clock) disable iff (!nReset)
        Redirect |-> DecodeIn.Valid ##1 !DecodeIn.Valid);

endmodule

`default_nettype wire

// ==== design/fetchStage.sv ====
// Fetch stage holding the program counter and the fetch-to-decode register
`default_nettype none
`timescale 1ns/1ps

module fetchStage #(
    parameter int AddrWidth = 16
) (
    input  logic                   Clock,
    input  logic                   nReset,
    input  logic                   Stall,
    input  logic                   Redirect,
    input  logic [AddrWidth-1:0]   TargetPc,
    input  logic [31:0]            InstrMem,
    output logic [AddrWidth-1:0]   InstrAddr,
    output pipePkg::fetchDecode_t  FetchOut
);

    logic [AddrWidth-1:0] Pc;

    assign InstrAddr = Pc;

    // Redirect has priority over a load-use hold
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            Pc       <= '0;
            FetchOut <= '0;
        end
        else if (Redirect)
        begin
            Pc             <= TargetPc;
            FetchOut.Valid <= 1'b0;
        end
        else if (!Stall)
        begin
            Pc                 <= Pc + AddrWidth'(4);
            FetchOut.Valid     <= 1'b1;
            FetchOut.Pc        <= 16'(Pc);
            FetchOut.Instr.Raw <= InstrMem;
        end
    end

    // Branch and jump targets from execute keep the word alignment
    assert property (@(posedge Clock) disable iff (!nReset) InstrAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/hazardUnit.sv ====
// Forwarding select and load-use stall logic for operands read in decode
`default_nettype none
`timescale 1ns/1ps

module hazardUnit (
    input  logic [4:0]              RsAddr,
    input  logic [4:0]              RtAddr,
    input  pipePkg::decodeExecute_t DecodeEx,
    input  pipePkg::executeMemory_t ExMem,
    input  pipePkg::writePort_t     WritePort,
    output pipePkg::forwardSel_e    ForwardA,
    output pipePkg::forwardSel_e    ForwardB,
    output logic                    Stall
);

    logic LoadInExec;
    logic LoadInMem;

    // Nearest producer wins
    function automatic pipePkg::forwardSel_e selectSource(input logic [4:0] Src);
        if (Src == 5'd0)
            return pipePkg::FwdReg;
        else if (DecodeEx.Valid && DecodeEx.Ctrl.RegWrite && !DecodeEx.Ctrl.MemRead
                 && DecodeEx.DestAddr == Src)
            return pipePkg::FwdExec;
        else if (ExMem.Valid && ExMem.Ctrl.RegWrite && !ExMem.Ctrl.MemRead
                 && ExMem.DestAddr == Src)
            return pipePkg::FwdMem;
        else if (WritePort.Enable && WritePort.Addr == Src)
            return pipePkg::FwdWb;
        else
            return pipePkg::FwdReg;
    endfunction

    function automatic logic loadHits(input logic IsLoad, input logic [4:0] Dest);
        return IsLoad && Dest != 5'd0 && (Dest == RsAddr || Dest == RtAddr);
    endfunction

    // Load data is only usable once it reaches write-back
    always_comb
    begin
        ForwardA   = selectSource(RsAddr);
        ForwardB   = selectSource(RtAddr);
        LoadInExec = loadHits(DecodeEx.Valid && DecodeEx.Ctrl.MemRead, DecodeEx.DestAddr);
        LoadInMem  = loadHits(ExMem.Valid && ExMem.Ctrl.MemRead, ExMem.DestAddr);
        Stall      = LoadInExec || LoadInMem;
    end

endmodule

`default_nettype wire

// ==== design/isaPkg.sv ====
// Instruction set encodings and formats shared by the decoder and the testbench
`default_nettype none

package isaPkg;

    // -------------------------------------------------------------------
    // Primary opcodes
    // -------------------------------------------------------------------
    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpJ       = 6'h02,
        OpBeq     = 6'h04,
        OpBne     = 6'h05,
        OpAddiu   = 6'h09,
        OpOri     = 6'h0d,
        OpLw      = 6'h23,
        OpSw      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnSlt  = 6'h2a
    } funct_e;

    // -------------------------------------------------------------------
    // Instruction word views
    // -------------------------------------------------------------------
    typedef struct packed {
        opcode_e    Opcode;
        logic [4:0] Rs;
        logic [4:0] Rt;
        logic [4:0] Rd;
        logic [4:0] Shamt;
        funct_e     Funct;
    } rFormat_t;

    typedef struct packed {
        opcode_e     Opcode;
        logic [4:0]  Rs;
        logic [4:0]  Rt;
        logic [15:0] Imm16;
    } iFormat_t;

    // Jump index is taken from the raw view
    typedef union packed {
        rFormat_t    R;
        iFormat_t    I;
        logic [31:0] Raw;
    } instr_u;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSll
    } aluOp_e;

endpackage

`default_nettype wire

// ==== design/memoryStage.sv ====
// Memory stage driving the data port, with the write-back register and result select
`default_nettype none
`timescale 1ns/1ps

module memoryStage #(
    parameter int AddrWidth = 16
) (
    input  logic                      Clock,
    input  logic                      nReset,
    input  pipePkg::executeMemory_t   MemIn,
    input  logic [31:0]               MemData,
    output logic [AddrWidth-1:0]      MemAddr,
    output logic [31:0]               WriteData,
    output logic                      MemWrite,
    output logic                      MemRead,
    output logic [31:0]               MemResult,
    output pipePkg::memoryWriteBack_t WbOut,
    output pipePkg::writePort_t       WritePort
);

    assign MemAddr   = MemIn.AluResult[AddrWidth-1:0];
    assign WriteData = MemIn.StoreData;
    assign MemWrite  = MemIn.Valid && MemIn.Ctrl.MemWrite;
    assign MemRead   = MemIn.Valid && MemIn.Ctrl.MemRead;
    assign MemResult = MemIn.AluResult;

    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
            WbOut <= '0;
        else
        begin
            WbOut.Valid     <= MemIn.Valid;
            WbOut.RegWrite  <= MemIn.Ctrl.RegWrite;
            WbOut.MemToReg  <= MemIn.Ctrl.MemToReg;
            WbOut.DestAddr  <= MemIn.DestAddr;
            WbOut.AluResult <= MemIn.AluResult;
        end
    end

    // Load data arrives from the registered RAM during write-back
    assign WritePort.Enable = WbOut.Valid && WbOut.RegWrite;
    assign WritePort.Addr   = WbOut.DestAddr;
    assign WritePort.Data   = WbOut.MemToReg ? MemData : WbOut.AluResult;

    assert property (@(posedge Clock) disable iff (!nReset) !(MemRead && MemWrite));

endmodule

`default_nettype wire

// ==== design/miniMipsCore.sv ====
// Top level of the five-stage core, with instruction and data memories kept outside
`default_nettype none
`timescale 1ns/1ps

module miniMipsCore #(
    parameter int AddrWidth = 16
) (
    input  logic                 Clock,
    input  logic                 nReset,
    input  logic [31:0]          InstrMem,
    input  logic [31:0]          MemData,
    input  logic [4:0]           RegAddr,
    output logic [AddrWidth-1:0] InstrAddr,
    output logic [AddrWidth-1:0] MemAddr,
    output logic [31:0]          WriteData,
    output logic                 MemWrite,
    output logic                 MemRead,
    output logic [31:0]          RegData,
    output logic                 nStall
);

    pipePkg::fetchDecode_t   FetchDecode;
    pipePkg::decodeExecute_t DecodeExecute;
    pipePkg::executeMemory_t ExecuteMemory;
    pipePkg::writePort_t     WritePort;
    pipePkg::forwardSel_e    ForwardA;
    pipePkg::forwardSel_e    ForwardB;
    logic                    Stall;
    logic                    Redirect;
    logic [AddrWidth-1:0]    TargetPc;
    logic [4:0]              RsAddr;
    logic [4:0]              RtAddr;
    logic [31:0]             ExecResult;
    logic [31:0]             MemResult;

    assign nStall = !Stall;

    fetchStage #(.AddrWidth(AddrWidth)) u_fetch (
        .Clock    (Clock),
        .nReset   (nReset),
        .Stall    (Stall),
        .Redirect (Redirect),
        .TargetPc (TargetPc),
        .InstrMem (InstrMem),
        .InstrAddr(InstrAddr),
        .FetchOut (FetchDecode)
    );

    decodeStage #(.AddrWidth(AddrWidth)) u_decode (
        .Clock     (Clock),
        .nReset    (nReset),
        .FetchIn   (FetchDecode),
        .Stall     (Stall),
        .Redirect  (Redirect),
        .ForwardA  (ForwardA),
        .ForwardB  (ForwardB),
        .ExecResult(ExecResult),
        .MemResult (MemResult),
        .WritePort (WritePort),
        .RegAddr   (RegAddr),
        .RsAddr    (RsAddr),
        .RtAddr    (RtAddr),
        .DecodeOut (DecodeExecute),
        .RegData   (RegData)
    );

    executeStage #(.AddrWidth(AddrWidth)) u_execute (
        .Clock     (Clock),
        .nReset    (nReset),
        .DecodeIn  (DecodeExecute),
        .ExecResult(ExecResult),
        .Redirect  (Redirect),
        .TargetPc  (TargetPc),
        .ExecOut   (ExecuteMemory)
    );

    memoryStage #(.AddrWidth(AddrWidth)) u_memory (
        .Clock    (Clock),
        .nReset   (nReset),
        .MemIn    (ExecuteMemory),
        .MemData  (MemData),
        .MemAddr  (MemAddr),
        .WriteData(WriteData),
        .MemWrite (MemWrite),
        .MemRead  (MemRead),
        .MemResult(MemResult),
        .WbOut    (),
        .WritePort(WritePort)
    );

    hazardUnit u_hazard (
        .RsAddr   (RsAddr),
        .RtAddr   (RtAddr),
        .DecodeEx (DecodeExecute),
        .ExMem    (ExecuteMemory),
        .WritePort(WritePort),
        .ForwardA (ForwardA),
        .ForwardB (ForwardB),
        .Stall    (Stall)
    );

endmodule

`default_nettype wire

// ==== design/pipePkg.sv ====
// Pipeline register layouts and control bundles passed between the core stages
`default_nettype none

package pipePkg;

    typedef struct packed {
        logic           RegWrite;
        logic           MemRead;
        logic           MemWrite;
        logic           MemToReg;
        logic           AluSrcImm;
        logic           Branch;
        logic           BranchNe;
        logic           Jump;
        isaPkg::aluOp_e AluOp;
    } ctrl_t;

    typedef struct packed {
        logic           Valid;
        logic [15:0]    Pc;
        isaPkg::instr_u Instr;
    } fetchDecode_t;

    typedef struct packed {
        logic        Valid;
        ctrl_t       Ctrl;
        logic [15:0] Pc;
        logic [4:0]  RsAddr;
        logic [4:0]  RtAddr;
        logic [4:0]  DestAddr;
        logic [31:0] RsData;
        logic [31:0] RtData;
        logic [31:0] Imm;
        logic [4:0]  Shamt;
    } decodeExecute_t;

    typedef struct packed {
        logic        Valid;
        ctrl_t       Ctrl;
        logic [4:0]  DestAddr;
        logic [31:0] AluResult;
        logic [31:0] StoreData;
    } executeMemory_t;

    typedef struct packed {
        logic        Valid;
        logic        RegWrite;
        logic        MemToReg;
        logic [4:0]  DestAddr;
        logic [31:0] AluResult;
    } memoryWriteBack_t;

    typedef struct packed {
        logic        Enable;
        logic [4:0]  Addr;
        logic [31:0] Data;
    } writePort_t;

    typedef enum logic [1:0] {
        FwdReg,
        FwdExec,
        FwdMem,
        FwdWb
    } forwardSel_e;

endpackage

`default_nettype wire

// ==== design/regFile.sv ====
// General purpose register file with two read ports and a debug read port
`default_nettype none
`timescale 1ns/1ps

module regFile (
    input  logic                Clock,
    input  logic                nReset,
    input  logic [4:0]          RsAddr,
    input  logic [4:0]          RtAddr,
    input  logic [4:0]          RegAddr,
    input  pipePkg::writePort_t WritePort,
    output logic [31:0]         RsData,
    output logic [31:0]         RtData,
    output logic [31:0]         RegData
);

    logic [31:0] Regs [32];

    // Write-through so decode sees the value being written this cycle
    function automatic logic [31:0] readReg(input logic [4:0] Addr);
        if (Addr == 5'd0)
            return '0;
        else if (WritePort.Enable && WritePort.Addr == Addr)
            return WritePort.Data;
        else
            return Regs[Addr];
    endfunction

    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            for (int i = 0; i < 32; i++)
                Regs[i] <= '0;
        end
        else if (WritePort.Enable && WritePort.Addr != 5'd0)
            Regs[WritePort.Addr] <= WritePort.Data;
    end

    always_comb
    begin
        RsData  = readReg(RsAddr);
        RtData  = readReg(RtAddr);
        RegData = readReg(RegAddr);
    end

    assert property (@(posedge Clock) disable iff (!nReset)
        WritePort.Enable && WritePort.Addr == 5'd0 |=> Regs[0] == '0);

endmodule

`default_nettype wire

// ==== miniMips.f ====
+incdir+sim
design/isaPkg.sv
design/pipePkg.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/hazardUnit.sv
design/miniMipsCore.sv
sim/miniMipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f miniMips.f --top-module miniMipsCoreTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "tests failed" sim.log; then
    exit 1
fi
grep -q "all tests passed" sim.log

// ==== sim/programTable.svh ====
// Program words and expected results, included inside the core testbench module
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

typedef enum logic [1:0] {
    ResNone,
    ResReg,
    ResLoad,
    ResStore
} result_e;

// Addr is the store address, or the byte address a loaded value came from
typedef struct packed {
    logic [31:0] Instr;
    result_e     Kind;
    logic [4:0]  Reg;
    logic [15:0] Addr;
    logic [31:0] Value;
} row_t;

localparam int ProgLen = 26;
localparam logic [15:0] LoopAddr = 16'd100;

row_t progTable [ProgLen];

function automatic logic [31:0] rType(input isaPkg::funct_e Fn, input logic [4:0] Rd,
                                      input logic [4:0] Rs, input logic [4:0] Rt,
                                      input logic [4:0] Sh);
    isaPkg::instr_u W;
    W.R = '{isaPkg::OpSpecial, Rs, Rt, Rd, Sh, Fn};
    return W.Raw;
endfunction

function automatic logic [31:0] iType(input isaPkg::opcode_e Op, input logic [4:0] Rt,
                                      input logic [4:0] Rs, input logic [15:0] Imm);
    isaPkg::instr_u W;
    W.I = '{Op, Rs, Rt, Imm};
    return W.Raw;
endfunction

function automatic logic [31:0] jType(input logic [25:0] Index);
    return {6'h02, Index};
endfunction

task automatic fillTable();
    // ALU chain, each result feeding the next
    progTable[0]  = '{iType(isaPkg::OpAddiu, 1, 0, 16'd5), ResReg, 5'd1, 16'h0, 32'd5};
    progTable[1]  = '{iType(isaPkg::OpAddiu, 2, 1, 16'hfffd), ResReg, 5'd2, 16'h0, 32'd2};
    progTable[2]  = '{rType(isaPkg::FnAddu, 3, 1, 2, 0), ResReg, 5'd3, 16'h0, 32'd7};
    progTable[3]  = '{rType(isaPkg::FnSubu, 4, 2, 3, 0), ResReg, 5'd4, 16'h0, 32'hfffffffb};
    progTable[4]  = '{rType(isaPkg::FnAnd, 5, 4, 1, 0), ResReg, 5'd5, 16'h0, 32'd1};
    progTable[5]  = '{rType(isaPkg::FnOr, 6, 5, 3, 0), ResReg, 5'd6, 16'h0, 32'd7};
    progTable[6]  = '{rType(isaPkg::FnXor, 7, 6, 4, 0), ResReg, 5'd7, 16'h0, 32'hfffffffc};
    progTable[7]  = '{rType(isaPkg::FnSlt, 8, 4, 6, 0), ResReg, 5'd8, 16'h0, 32'd1};
    progTable[8]  = '{rType(isaPkg::FnSll, 9, 0, 8, 4), ResReg, 5'd9, 16'h0, 32'h10};
    progTable[9]  = '{iType(isaPkg::OpOri, 12, 0, 16'h8001), ResReg, 5'd12, 16'h0, 32'h8001};
    // Load and immediate use
    progTable[10] = '{iType(isaPkg::OpLw, 10, 0, 16'h8), ResLoad, 5'd10, 16'h8, 32'h0};
    progTable[11] = '{rType(isaPkg::FnAddu, 11, 10, 0, 0), ResLoad, 5'd11, 16'h8, 32'h0};
    // Stores
    progTable[12] = '{iType(isaPkg::OpSw, 3, 0, 16'h40), ResStore, 5'd0, 16'h40, 32'd7};
    progTable[13] = '{iType(isaPkg::OpSw, 7, 9, 16'h44), ResStore, 5'd0, 16'h54,
                      32'hfffffffc};
    progTable[14] = '{iType(isaPkg::OpAddiu, 0, 0, 16'h77), ResReg, 5'd0, 16'h0, 32'd0};
    // Branches, with markers in the skipped slots
    progTable[15] = '{iType(isaPkg::OpBeq, 1, 1, 16'd2), ResNone, 5'd0, 16'h0, 32'd0};
    progTable[16] = '{iType(isaPkg::OpAddiu, 13, 0, 16'd1), ResReg, 5'd13, 16'h0, 32'd0};
    progTable[17] = '{iType(isaPkg::OpAddiu, 14, 0, 16'd1), ResReg, 5'd14, 16'h0, 32'd0};
    progTable[18] = '{iType(isaPkg::OpBne, 1, 1, 16'd1), ResNone, 5'd0, 16'h0, 32'd0};
    progTable[19] = '{iType(isaPkg::OpAddiu, 15, 0, 16'h33), ResReg, 5'd15, 16'h0, 32'h33};
    progTable[20] = '{iType(isaPkg::OpBne, 2, 1, 16'd1), ResNone, 5'd0, 16'h0, 32'd0};
    progTable[21] = '{iType(isaPkg::OpAddiu, 16, 0, 16'd1), ResReg, 5'd16, 16'h0, 32'd0};
    progTable[22] = '{jType(26'd24), ResNone, 5'd0, 16'h0, 32'd0};
    progTable[23] = '{iType(isaPkg::OpAddiu, 17, 0, 16'd1), ResReg, 5'd17, 16'h0, 32'd0};
    progTable[24] = '{iType(isaPkg::OpSw, 15, 0, 16'h48), ResStore, 5'd0, 16'h48, 32'h33};
    // Self loop ends the program
    progTable[25] = '{jType(26'd25), ResNone, 5'd0, 16'h0, 32'd0};
endtask

`endif

// ==== sim/miniMipsCoreTb.sv ====
// Testbench for the core, with instruction ROM, data RAM, store checks and register readback
`default_nettype none
`timescale 1ns/1ps

module miniMipsCoreTb;

    localparam int AddrWidth = 16;

    `include "programTable.svh"

    localparam int CycleLimit = 4 * ProgLen + 50;

    logic                 Clock;
    logic                 nReset;
    logic [31:0]          InstrMem;
    logic [31:0]          MemData;
    logic [4:0]           RegAddr;
    logic [AddrWidth-1:0] InstrAddr;
    logic [AddrWidth-1:0] MemAddr;
    logic [31:0]          WriteData;
    logic                 MemWrite;
    logic                 MemRead;
    logic [31:0]          RegData;
    logic                 nStall;

    logic [31:0]          rom [64];
    logic [31:0]          ram [64];
    logic [31:0]          shadow [64];
    logic [31:0]          readWord;
    logic [AddrWidth-1:0] storeAddrQ [$];
    logic [31:0]          storeDataQ [$];
    logic                 sawStall;
    integer               seed;
    int                   cycles;

    miniMipsCore #(.AddrWidth(AddrWidth)) u_dut (
        .Clock    (Clock),
        .nReset   (nReset),
        .InstrMem (InstrMem),
        .MemData  (MemData),
        .RegAddr  (RegAddr),
        .InstrAddr(InstrAddr),
        .MemAddr  (MemAddr),
        .WriteData(WriteData),
        .MemWrite (MemWrite),
        .MemRead  (MemRead),
        .RegData  (RegData),
        .nStall   (nStall)
    );

    initial
    begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    assign InstrMem = rom[InstrAddr[7:2]];

    // -------------------------------------------------------------------
    // Compare tasks
    // -------------------------------------------------------------------
    task automatic checkWord(input string Name, input logic [31:0] Got,
                             input logic [31:0] Exp);
        if (Got !== Exp)
        begin
            $display("Fail %s: got %h expected %h", Name, Got, Exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic checkStore(input logic [AddrWidth-1:0] Addr, input logic [31:0] Data);
        logic [AddrWidth-1:0] expAddr;
        logic [31:0]          expData;
        if (storeAddrQ.size() == 0)
        begin
            $display("A store was seen after all expected stores were done");
            $display("tests failed");
            $fatal(1);
        end
        expAddr = storeAddrQ.pop_front();
        expData = storeDataQ.pop_front();
        if (Addr !== expAddr || Data !== expData)
        begin
            $display("Fail MemAddr/WriteData: got %h/%h expected %h/%h",
                     Addr, Data, expAddr, expData);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // Data RAM with registered read, stores checked in order
    always @(posedge Clock)
    begin
        if (nReset && MemWrite)
        begin
            checkStore(MemAddr, WriteData);
            ram[MemAddr[7:2]] = WriteData;
        end
        if (nReset && MemRead)
            readWord = ram[MemAddr[7:2]];
        if (nReset && !nStall)
            sawStall = 1'b1;
        #1 MemData = readWord;
    end

    always @(posedge Clock)
    begin
        if (nReset)
        begin
            cycles = cycles + 1;
            if (cycles >= CycleLimit)
            begin
                $display("Timeout: the program did not finish in %0d cycles", CycleLimit);
                $display("tests failed");
                $fatal(1);
            end
        end
    end

    initial
    begin
        logic [31:0] exp;
        nReset   = 1'b0;
        MemData  = '0;
        RegAddr  = '0;
        readWord = '0;
        sawStall = 1'b0;
        cycles   = 0;
        seed     = 8570;
        fillTable();
        for (int i = 0; i < 64; i++)
        begin
            rom[i]    = jType(26'(i));
            ram[i]    = $random(seed);
            shadow[i] = ram[i];
        end
        for (int i = 0; i < ProgLen; i++)
        begin
            rom[i] = progTable[i].Instr;
            if (progTable[i].Kind == ResStore)
            begin
                storeAddrQ.push_back(progTable[i].Addr);
                storeDataQ.push_back(progTable[i].Value);
            end
        end

        // Quiet data port during reset
        repeat (10)
        begin
            @(posedge Clock);
            #1;
            checkWord("MemWrite", 32'(MemWrite), 32'd0);
            checkWord("MemRead", 32'(MemRead), 32'd0);
            checkWord("InstrAddr", 32'(InstrAddr), 32'd0);
        end
        nReset = 1'b1;

        // Run to the self loop, then let the pipeline drain
        while (InstrAddr != LoopAddr)
            @(posedge Clock);
        repeat (6) @(posedge Clock);

        for (int i = 0; i < ProgLen; i++)
        begin
            if (progTable[i].Kind == ResReg || progTable[i].Kind == ResLoad)
            begin
                if (progTable[i].Kind == ResLoad)
                    exp = shadow[progTable[i].Addr[7:2]];
                else
                    exp = progTable[i].Value;
                #1 RegAddr = progTable[i].Reg;
                @(posedge Clock);
                checkWord($sformatf("RegData[r%0d]", progTable[i].Reg), RegData, exp);
            end
        end

        if (!sawStall || storeAddrQ.size() != 0)
        begin
            if (!sawStall)
                $display("The load-use pair never stalled the pipeline");
            else
                $display("Some expected stores never happened");
            $display("tests failed");
            $fatal(1);
        end
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
